/* Makefile */
# Verilator simulation of the cpu_top testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/cpu_isa_pkg.sv */
package cpu_isa_pkg;

    localparam int data_width     = 32;
    localparam int reg_addr_width = 5;
    localparam int opcode_width   = 6;
    localparam int funct_width    = 6;
    localparam int shamt_width    = 5;
    localparam int imm_width      = 16;

    // major opcodes in instr[31:26]
    typedef enum logic [opcode_width-1:0] {
        op_special = 6'h00,
        op_addiu   = 6'h09,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_t;

    // function codes of the special opcode
    typedef enum logic [funct_width-1:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2a
    } funct_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_lui
    } alu_op_t;

endpackage

/* design/cpu_pipe_pkg.sv */
package cpu_pipe_pkg;

    import cpu_isa_pkg::*;

    // one fetched word with its address
    typedef struct packed {
        logic [data_width-1:0] pc;
        logic [data_width-1:0] instr;
    } fetch_entry_t;

    // decode to execute
    typedef struct packed {
        logic                      valid;
        logic [data_width-1:0]     pc;
        alu_op_t                   alu_op;
        logic [data_width-1:0]     operand_a;
        logic [data_width-1:0]     operand_b;
        logic [data_width-1:0]     store_data;
        logic [reg_addr_width-1:0] dest;
        logic                      reg_write;
        logic                      is_load;
        logic                      is_store;
    } exe_uop_t;

    // execute to writeback
    typedef struct packed {
        logic                      valid;
        logic [data_width-1:0]     pc;
        logic [data_width-1:0]     result;
        logic [reg_addr_width-1:0] dest;
        logic                      reg_write;
        logic                      is_load;
    } wb_uop_t;

    // register file write, also fed back for forwarding
    typedef struct packed {
        logic                      en;
        logic [reg_addr_width-1:0] addr;
        logic [data_width-1:0]     data;
    } reg_write_t;

endpackage

/* design/cpu_top.sv */
module cpu_top import cpu_pipe_pkg::*; #(
    parameter int          queue_depth = 4,
    parameter logic [31:0] reset_pc    = 32'hbfc0_0000
) (
    input  logic        clk,
    input  logic        reset,
    // instruction sram
    output logic        inst_sram_en,
    output logic [3:0]  inst_sram_wen,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,
    // data sram
    output logic        data_sram_en,
    output logic [3:0]  data_sram_wen,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    // debug writeback
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_wen,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    logic         push;
    fetch_entry_t fetch_entry;
    logic         credit_return;
    fetch_entry_t head;
    logic         not_empty;
    logic         pop;
    logic [4:0]   rs_addr;
    logic [4:0]   rt_addr;
    logic [31:0]  rs_data;
    logic [31:0]  rt_data;
    exe_uop_t     exe_uop;
    logic [31:0]  exe_result;
    wb_uop_t      wb_uop;
    reg_write_t   wb_write;

    // instruction side is read only
    assign inst_sram_wen   = 4'h0;
    assign inst_sram_wdata = 32'h0;

    // --------------------
    // front end
    fetch_unit #(
        .queue_depth (queue_depth),
        .reset_pc    (reset_pc)
    ) u_fetch (
        .clk             (clk),
        .reset           (reset),
        .credit_return   (credit_return),
        .inst_sram_rdata (inst_sram_rdata),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .push            (push),
        .entry           (fetch_entry)
    );

    inst_queue #(
        .queue_depth (queue_depth)
    ) u_queue (
        .clk           (clk),
        .reset         (reset),
        .push          (push),
        .entry         (fetch_entry),
        .pop           (pop),
        .head          (head),
        .not_empty     (not_empty),
        .credit_return (credit_return)
    );

    // --------------------
    // back end
    decode_stage u_decode (
        .clk        (clk),
        .reset      (reset),
        .head       (head),
        .not_empty  (not_empty),
        .pop        (pop),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .exe_fwd    (exe_uop),
        .exe_result (exe_result),
        .wb_fwd     (wb_write),
        .uop        (exe_uop)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr      (wb_write)
    );

    execute_stage u_execute (
        .clk             (clk),
        .reset           (reset),
        .uop             (exe_uop),
        .result          (exe_result),
        .data_sram_en    (data_sram_en),
        .data_sram_wen   (data_sram_wen),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .wb              (wb_uop)
    );

    writeback_stage u_writeback (
        .wb                (wb_uop),
        .data_sram_rdata   (data_sram_rdata),
        .wr                (wb_write),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

/* design/decode_stage.sv */
module decode_stage import cpu_isa_pkg::*; import cpu_pipe_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  fetch_entry_t head,
    input  logic         not_empty,
    output logic         pop,
    output logic [4:0]   rs_addr,
    output logic [4:0]   rt_addr,
    input  logic [31:0]  rs_data,
    input  logic [31:0]  rt_data,
    input  exe_uop_t     exe_fwd,
    input  logic [31:0]  exe_result,
    input  reg_write_t   wb_fwd,
    output exe_uop_t     uop
);

    opcode_t                   op;
    funct_t                    fn;
    logic [reg_addr_width-1:0] rs;
    logic [reg_addr_width-1:0] rt;
    logic [reg_addr_width-1:0] rd;
    logic [shamt_width-1:0]    shamt;
    logic [imm_width-1:0]      imm;
    logic [data_width-1:0]     imm_sext;
    logic [data_width-1:0]     imm_zext;
    logic [data_width-1:0]     rs_val;
    logic [data_width-1:0]     rt_val;
    logic                      use_rs;
    logic                      use_rt;
    logic                      stall;
    exe_uop_t                  dec;

    // --------------------
    // instruction fields
    assign op       = opcode_t'(head.instr[31:26]);
    assign fn       = funct_t'(head.instr[5:0]);
    assign rs       = head.instr[25:21];
    assign rt       = head.instr[20:16];
    assign rd       = head.instr[15:11];
    assign shamt    = head.instr[10:6];
    assign imm      = head.instr[15:0];
    assign imm_sext = {{(data_width - imm_width){imm[imm_width-1]}}, imm};
    assign imm_zext = data_width'(imm);
    assign rs_addr  = rs;
    assign rt_addr  = rt;

    // youngest producer wins, execute before writeback
    function automatic logic [data_width-1:0] fwd(
        input logic [reg_addr_width-1:0] addr,
        input logic [data_width-1:0]     rf_data,
        input exe_uop_t                  ex,
        input logic [data_width-1:0]     ex_data,
        input reg_write_t                wb
    );
        if (addr == '0) begin
            return '0;
        end
        if (ex.valid && ex.reg_write && (ex.dest == addr)) begin
            return ex_data;
        end
        if (wb.en && (wb.addr == addr)) begin
            return wb.data;
        end
        return rf_data;
    endfunction

    assign rs_val = fwd(rs, rs_data, exe_fwd, exe_result, wb_fwd);
    assign rt_val = fwd(rt, rt_data, exe_fwd, exe_result, wb_fwd);

    // --------------------
    // decoder
    always_comb begin
        dec        = '0;
        dec.pc     = head.pc;
        dec.alu_op = alu_add;
        use_rs     = 1'b0;
        use_rt     = 1'b0;
        case (op)
            op_special: begin
                dec.dest      = rd;
                dec.reg_write = 1'b1;
                dec.operand_a = rs_val;
                dec.operand_b = rt_val;
                use_rs        = 1'b1;
                use_rt        = 1'b1;
                case (fn)
                    fn_sll, fn_srl: begin
                        dec.alu_op    = (fn == fn_sll) ? alu_sll : alu_srl;
                        dec.operand_a = rt_val;
                        dec.operand_b = data_width'(shamt);
                        use_rs        = 1'b0;
                    end
                    fn_addu: dec.alu_op = alu_add;
                    fn_subu: dec.alu_op = alu_sub;
                    fn_and:  dec.alu_op = alu_and;
                    fn_or:   dec.alu_op = alu_or;
                    fn_xor:  dec.alu_op = alu_xor;
                    fn_slt:  dec.alu_op = alu_slt;
                    default: dec.reg_write = 1'b0;
                endcase
            end
            op_addiu, op_ori, op_lui, op_lw: begin
                dec.dest      = rt;
                dec.reg_write = 1'b1;
                dec.is_load   = (op == op_lw);
                dec.operand_a = rs_val;
                dec.operand_b = (op == op_ori || op == op_lui) ? imm_zext : imm_sext;
                use_rs        = (op != op_lui);
                if (op == op_ori) begin
                    dec.alu_op = alu_or;
                end else if (op == op_lui) begin
                    dec.alu_op = alu_lui;
                end
            end
            op_sw: begin
                dec.is_store   = 1'b1;
                dec.operand_a  = rs_val;
                dec.operand_b  = imm_sext;
                dec.store_data = rt_val;
                use_rs         = 1'b1;
                use_rt         = 1'b1;
            end
            // anything else retires as a nop
            default: ;
        endcase
    end

    // load result only exists in writeback, so wait one cycle
    assign stall = exe_fwd.valid && exe_fwd.is_load && (exe_fwd.dest != '0) &&
                   ((use_rs && (exe_fwd.dest == rs)) || (use_rt && (exe_fwd.dest == rt)));
    assign pop   = not_empty && !stall;

    always_ff @(posedge clk) begin
        uop <= dec;
        if (reset) begin
            uop.valid <= 1'b0;
        end else begin
            // bubble on stall or empty queue
            uop.valid <= pop;
        end
    end

endmodule

/* design/execute_stage.sv */
module execute_stage import cpu_isa_pkg::*; import cpu_pipe_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  exe_uop_t    uop,
    output logic [31:0] result,
    output logic        data_sram_en,
    output logic [3:0]  data_sram_wen,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    output wb_uop_t     wb
);

    // --------------------
    // alu
    always_comb begin
        case (uop.alu_op)
            alu_add: result = uop.operand_a + uop.operand_b;
            alu_sub: result = uop.operand_a - uop.operand_b;
            alu_and: result = uop.operand_a & uop.operand_b;
            alu_or:  result = uop.operand_a | uop.operand_b;
            alu_xor: result = uop.operand_a ^ uop.operand_b;
            alu_slt: result = {31'b0, $signed(uop.operand_a) < $signed(uop.operand_b)};
            alu_sll: result = uop.operand_a << uop.operand_b[4:0];
            alu_srl: result = uop.operand_a >> uop.operand_b[4:0];
            alu_lui: result = {uop.operand_b[15:0], 16'h0};
            default: result = 32'h0;
        endcase
    end

    // lw and sw address is base plus offset from the alu
    assign data_sram_en    = uop.valid && (uop.is_load || uop.is_store);
    assign data_sram_wen   = (uop.valid && uop.is_store) ? 4'hf : 4'h0;
    assign data_sram_addr  = result;
    assign data_sram_wdata = uop.store_data;

    always_ff @(posedge clk) begin
        wb.pc        <= uop.pc;
        wb.result    <= result;
        wb.dest      <= uop.dest;
        wb.reg_write <= uop.reg_write;
        wb.is_load   <= uop.is_load;
        if (reset) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= uop.valid;
        end
    end

endmodule

/* design/fetch_unit.sv */
module fetch_unit import cpu_pipe_pkg::*; #(
    parameter int          queue_depth = 4,
    parameter logic [31:0] reset_pc    = 32'hbfc0_0000
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         credit_return,
    input  logic [31:0]  inst_sram_rdata,
    output logic         inst_sram_en,
    output logic [31:0]  inst_sram_addr,
    output logic         push,
    output fetch_entry_t entry
);

    localparam int credit_width = $clog2(queue_depth + 1);

    logic [31:0]             pc;
    logic [credit_width-1:0] credits;
    logic                    running;
    logic                    issue;
    logic                    pend_valid;
    logic [31:0]             pend_pc;

    // no request in the first cycle out of reset
    assign issue          = running && (credits != '0);
    assign inst_sram_en   = issue;
    assign inst_sram_addr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            running    <= 1'b0;
            pc         <= reset_pc;
            credits    <= credit_width'(queue_depth);
            pend_valid <= 1'b0;
        end else begin
            running    <= 1'b1;
            pend_valid <= issue;
            if (issue) begin
                pc <= pc + 32'd4;
            end
            // one credit per request, one back per pop
            credits <= credits + credit_width'(credit_return) - credit_width'(issue);
        end
    end

    // address of the request in flight
    always_ff @(posedge clk) begin
        pend_pc <= pc;
    end

    // sram answers one cycle later
    assign push        = pend_valid;
    assign entry.pc    = pend_pc;
    assign entry.instr = inst_sram_rdata;

endmodule

/* design/inst_queue.sv */
module inst_queue import cpu_pipe_pkg::*; #(
    parameter int queue_depth = 4
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         push,
    input  fetch_entry_t entry,
    input  logic         pop,
    output fetch_entry_t head,
    output logic         not_empty,
    output logic         credit_return
);

    localparam int ptr_width   = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int count_width = $clog2(queue_depth + 1);

    fetch_entry_t           mem [queue_depth];
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] count;

    // wrap at queue_depth, which need not be a power of two
    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        if (ptr == ptr_width'(queue_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= entry;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count         <= count + count_width'(push) - count_width'(pop);
            credit_return <= pop;
        end
    end

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);

endmodule

/* design/reg_file.sv */
module reg_file import cpu_pipe_pkg::*; (
    input  logic        clk,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    input  reg_write_t  wr
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (wr.en && (wr.addr != 5'd0)) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // $0 reads as zero
    assign rs_data = (rs_addr == 5'd0) ? 32'h0 : regs[rs_addr];
    assign rt_data = (rt_addr == 5'd0) ? 32'h0 : regs[rt_addr];

endmodule

/* design/writeback_stage.sv */
module writeback_stage import cpu_pipe_pkg::*; (
    input  wb_uop_t     wb,
    input  logic [31:0] data_sram_rdata,
    output reg_write_t  wr,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_wen,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    logic [31:0] wdata;

    // load data arrives from the sram this cycle
    assign wdata = wb.is_load ? data_sram_rdata : wb.result;

    assign wr.en   = wb.valid && wb.reg_write && (wb.dest != 5'd0);
    assign wr.addr = wb.dest;
    assign wr.data = wdata;

    // --------------------
    // debug ports, byte enables all follow the single write enable
    assign debug_wb_pc       = wb.pc;
    assign debug_wb_rf_wen   = {4{wr.en}};
    assign debug_wb_rf_wnum  = wb.dest;
    assign debug_wb_rf_wdata = wdata;

endmodule

/* sources.f */
design/cpu_isa_pkg.sv
design/cpu_pipe_pkg.sv
design/fetch_unit.sv
design/inst_queue.sv
design/decode_stage.sv
design/reg_file.sv
design/execute_stage.sv
design/writeback_stage.sv
design/cpu_top.sv
tests/tb_cpu_top.sv

/* tests/tb_cpu_top.sv */
module tb_cpu_top;

    localparam int          clk_period   = 4;
    localparam int          reset_cycles = 8;
    localparam int          prog_len     = 400;
    localparam int          num_regs     = 7;
    localparam int          dmem_words   = 16;
    localparam int          drain_cycles = 20;
    localparam int          retire_limit = 10 * prog_len;
    localparam int          watchdog_cycles = 20 * prog_len;
    localparam logic [31:0] reset_pc     = 32'hbfc0_0000;

    // mips encodings
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;
    localparam logic [5:0] fn_sll     = 6'h00;
    localparam logic [5:0] fn_srl     = 6'h02;
    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_subu    = 6'h23;
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_xor     = 6'h26;
    localparam logic [5:0] fn_slt     = 6'h2a;

    logic        clk;
    logic        reset;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_wen;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_wen;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    integer      seed;
    logic [31:0] prog [prog_len];
    logic [31:0] dmem [dmem_words];
    logic [31:0] ref_mem [dmem_words];

    // expected retirements from the model
    logic [31:0] exp_wr_pc [$];
    logic [4:0]  exp_wr_num [$];
    logic [31:0] exp_wr_data [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];

    int          wr_seen = 0;
    int          st_seen = 0;
    int          mismatch_errors = 0;
    int          other_errors = 0;
    logic [31:0] next_fetch_addr = reset_pc;
    logic        out_of_reset = 1'b0;

    // requests seen mid cycle, answered after the next edge
    logic        inst_req_q = 1'b0;
    logic [31:0] inst_addr_q = '0;
    logic        data_req_q = 1'b0;
    logic [3:0]  data_wen_q = '0;
    logic [31:0] data_addr_q = '0;
    logic [31:0] data_wdata_q = '0;

    cpu_top #(
        .queue_depth (4),
        .reset_pc    (reset_pc)
    ) u_dut (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_wen     (inst_sram_wen),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // --------------------
    // program and model
    function automatic logic [31:0] fill_word(input int idx);
        logic [31:0] byte_addr;
        byte_addr = 32'(idx * 4);
        return {byte_addr[15:0] ^ 16'ha5c3, ~byte_addr[15:0]};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - reset_pc;
        if (offset[31:2] < prog_len) begin
            return prog[int'(offset[31:2])];
        end
        // sll $0, $0, 0
        return 32'h0;
    endfunction

    task automatic build_program();
        int          kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [31:0] r;
        logic [15:0] offset;
        for (int i = 0; i < prog_len; i++) begin
            r      = $random(seed);
            rs     = 5'({$random(seed)} % num_regs);
            rt     = 5'({$random(seed)} % num_regs);
            rd     = 5'({$random(seed)} % num_regs);
            offset = 16'(({$random(seed)} % dmem_words) * 4);
            kind   = int'({$random(seed)} % 16);
            if (i < num_regs - 1) begin
                // give every register a value before its first read
                prog[i] = {op_addiu, 5'd0, 5'(i + 1), r[15:0]};
            end else begin
                case (kind)
                    0:  prog[i] = {op_special, rs, rt, rd, 5'd0, fn_addu};
                    1:  prog[i] = {op_special, rs, rt, rd, 5'd0, fn_subu};
                    2:  prog[i] = {op_special, rs, rt, rd, 5'd0, fn_and};
                    3:  prog[i] = {op_special, rs, rt, rd, 5'd0, fn_or};
                    4:  prog[i] = {op_special, rs, rt, rd, 5'd0, fn_xor};
                    5:  prog[i] = {op_special, rs, rt, rd, 5'd0, fn_slt};
                    6:  prog[i] = {op_special, 5'd0, rt, rd, r[20:16], fn_sll};
                    7:  prog[i] = {op_special, 5'd0, rt, rd, r[20:16], fn_srl};
                    8:  prog[i] = {op_addiu, rs, rt, r[15:0]};
                    9:  prog[i] = {op_ori, rs, rt, r[15:0]};
                    10: prog[i] = {op_lui, 5'd0, rt, r[15:0]};
                    11, 12, 13: prog[i] = {op_lw, 5'd0, rt, offset};
                    default: prog[i] = {op_sw, 5'd0, rt, offset};
                endcase
            end
        end
    endtask

    task automatic run_model();
        logic [31:0] ref_regs [32];
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] val;
        logic [31:0] addr;
        logic [4:0]  dest;
        logic        writes;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        for (int i = 0; i < prog_len; i++) begin
            instr  = prog[i];
            a      = ref_regs[instr[25:21]];
            b      = ref_regs[instr[20:16]];
            sext   = {{16{instr[15]}}, instr[15:0]};
            addr   = a + sext;
            dest   = instr[20:16];
            val    = '0;
            writes = 1'b1;
            case (instr[31:26])
                op_special: begin
                    dest = instr[15:11];
                    case (instr[5:0])
                        fn_sll:  val = b << instr[10:6];
                        fn_srl:  val = b >> instr[10:6];
                        fn_addu: val = a + b;
                        fn_subu: val = a - b;
                        fn_and:  val = a & b;
                        fn_or:   val = a | b;
                        fn_xor:  val = a ^ b;
                        fn_slt:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: writes = 1'b0;
                    endcase
                end
                op_addiu: val = a + sext;
                op_ori:   val = a | {16'h0, instr[15:0]};
                op_lui:   val = {instr[15:0], 16'h0};
                op_lw:    val = ref_mem[addr[5:2]];
                op_sw: begin
                    writes = 1'b0;
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                    ref_mem[addr[5:2]] = b;
                end
                default: writes = 1'b0;
            endcase
            // $0 never shows up on the debug port
            if (writes && dest != 5'd0) begin
                ref_regs[dest] = val;
                exp_wr_pc.push_back(reset_pc + 32'(i * 4));
                exp_wr_num.push_back(dest);
                exp_wr_data.push_back(val);
            end
        end
    endtask

    // --------------------
    // sram models
    always @(posedge clk) begin
        #1;
        if (inst_req_q) begin
            inst_sram_rdata = fetch_word(inst_addr_q);
        end
        if (data_req_q) begin
            if (data_wen_q != 4'h0) begin
                dmem[data_addr_q[5:2]] = data_wdata_q;
            end else begin
                data_sram_rdata = dmem[data_addr_q[5:2]];
            end
        end
    end

    // --------------------
    // checks, sampled mid cycle
    task automatic check_idle();
        if (inst_sram_en !== 1'b0 || data_sram_en !== 1'b0 || debug_wb_rf_wen !== 4'h0) begin
            $display({"mismatch at %0t: inst_sram_en %b data_sram_en %b",
                      " debug_wb_rf_wen %h near reset"},
                     $time, inst_sram_en, data_sram_en, debug_wb_rf_wen);
            mismatch_errors++;
        end
    endtask

    task automatic check_fetch();
        // instruction side never writes
        if (inst_sram_wen !== 4'h0 || inst_sram_wdata !== 32'h0) begin
            $display("mismatch at %0t: inst_sram_wen %h wdata %h, expected both zero",
                     $time, inst_sram_wen, inst_sram_wdata);
            mismatch_errors++;
        end
        if (inst_sram_en === 1'b1) begin
            if (inst_sram_addr !== next_fetch_addr) begin
                $display("mismatch at %0t: fetch address %h, expected %h",
                         $time, inst_sram_addr, next_fetch_addr);
                mismatch_errors++;
            end
            // one word further per request
            next_fetch_addr = next_fetch_addr + 32'd4;
        end
    endtask

    task automatic check_reg_write();
        if (debug_wb_rf_wen !== 4'h0) begin
            if (debug_wb_rf_wen !== 4'hf) begin
                $display("mismatch at %0t: debug_wb_rf_wen %h, expected f", $time, debug_wb_rf_wen);
                mismatch_errors++;
            end
            if (wr_seen >= exp_wr_pc.size()) begin
                $display("error at %0t: register write to $%0d after all %0d expected writes",
                         $time, debug_wb_rf_wnum, exp_wr_pc.size());
                other_errors++;
            end else begin
                if (debug_wb_pc !== exp_wr_pc[wr_seen] ||
                    debug_wb_rf_wnum !== exp_wr_num[wr_seen] ||
                    debug_wb_rf_wdata !== exp_wr_data[wr_seen]) begin
                    $display("mismatch at %0t: write pc %h $%0d = %h, expected pc %h $%0d = %h",
                             $time, debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata,
                             exp_wr_pc[wr_seen], exp_wr_num[wr_seen], exp_wr_data[wr_seen]);
                    mismatch_errors++;
                end
                wr_seen++;
            end
        end
    endtask

    task automatic check_store();
        if (data_sram_en === 1'b1 && data_sram_wen !== 4'h0) begin
            if (st_seen >= exp_st_addr.size()) begin
                $display("error at %0t: store to %h after all %0d expected stores",
                         $time, data_sram_addr, exp_st_addr.size());
                other_errors++;
            end else begin
                if (data_sram_wen !== 4'hf || data_sram_addr !== exp_st_addr[st_seen] ||
                    data_sram_wdata !== exp_st_data[st_seen]) begin
                    $display("mismatch at %0t: store wen %h [%h] = %h, expected wen f [%h] = %h",
                             $time, data_sram_wen, data_sram_addr, data_sram_wdata,
                             exp_st_addr[st_seen], exp_st_data[st_seen]);
                    mismatch_errors++;
                end
                st_seen++;
            end
        end
    endtask

    always @(negedge clk) begin
        inst_req_q   = (inst_sram_en === 1'b1);
        inst_addr_q  = inst_sram_addr;
        data_req_q   = (data_sram_en === 1'b1);
        data_wen_q   = data_sram_wen;
        data_addr_q  = data_sram_addr;
        data_wdata_q = data_sram_wdata;
        if (reset || !out_of_reset) begin
            check_idle();
            if (!reset) begin
                out_of_reset = 1'b1;
            end
        end else begin
            check_fetch();
            check_reg_write();
            check_store();
        end
    end

    // --------------------
    // main sequence and watchdog
    initial begin
        int wait_cycles;
        reset           = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        seed            = 32'hec4f_eb0f;
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i]    = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        build_program();
        run_model();
        repeat (reset_cycles) @(posedge clk);
        #1 reset = 1'b0;
        // wait for the last retirement, bounded well inside the watchdog
        wait_cycles = 0;
        while ((wr_seen < exp_wr_pc.size() || st_seen < exp_st_addr.size()) &&
               wait_cycles < retire_limit) begin
            @(negedge clk);
            wait_cycles++;
        end
        // extra retirements would show up here
        repeat (drain_cycles) @(negedge clk);
        if (wr_seen != exp_wr_pc.size() || st_seen != exp_st_addr.size()) begin
            $display("error: retired %0d register writes and %0d stores, expected %0d and %0d",
                     wr_seen, st_seen, exp_wr_pc.size(), exp_st_addr.size());
            other_errors++;
        end
        $display("summary: %0d of %0d writes, %0d of %0d stores, %0d mismatches, %0d other errors",
                 wr_seen, exp_wr_pc.size(), st_seen, exp_st_addr.size(),
                 mismatch_errors, other_errors);
        if (mismatch_errors + other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #((watchdog_cycles + reset_cycles) * clk_period);
        $display("timeout: only %0d of %0d register writes and %0d of %0d stores retired",
                 wr_seen, exp_wr_pc.size(), st_seen, exp_st_addr.size());
        $display("Something failed");
        $finish;
    end

endmodule
